//--- common/hififo_pkg.sv
// hififo shared package: sizes, completion and request structs, arbiter states.

package hififo_pkg;

   // default channel count used by the top level.
   localparam int NUM_FIFOS_DEFAULT = 2;

   // reorder buffer geometry per channel.
   localparam int BLOCKS = 8; // blocks per channel.
   localparam int QWORDS_PER_BLOCK = 64; // 512 bytes per block.
   localparam int BLOCK_BITS = $clog2(BLOCKS); // block number width.
   localparam int INDEX_BITS = $clog2(QWORDS_PER_BLOCK); // quadword index width.

   // request flow limits.
   localparam int MAX_OUTSTANDING = 6; // requested but not yet read out.
   localparam int HOLDOFF_CYCLES = 3; // quiet cycles after an accept.

   // read completion, one quadword per beat.
   // tag[7:4] is the fifo number.
   // tag[2:0] is the block inside that fifo.
   typedef struct packed {
      logic valid; // one beat present.
      logic [7:0] tag; // fifo and block.
      logic [INDEX_BITS-1:0] index; // quadword inside the block.
      logic [63:0] data; // payload.
   } rc_t;

   // read request toward the host.
   // tag uses the same layout as rc_t.
   typedef struct packed {
      logic valid; // request shown.
      logic [7:0] tag; // fifo and block.
   } rr_t;

   // arbiter states.
   typedef enum logic {
      ARB_IDLE, // looking for the next requester.
      ARB_HOLD // request shown and waiting for accept.
   } arb_state_e;

endpackage

//--- design/block_ram.sv
// block_ram: simple dual-port memory, one write port and one registered read port.

`timescale 1ns/1ns

module block_ram #(
   parameter int DBITS = 64,
   parameter int ABITS = 9
) (
   input  logic clock,
   input  logic i_wr_en,
   input  logic [ABITS-1:0] i_wr_addr,
   input  logic [DBITS-1:0] i_wr_data,
   input  logic [ABITS-1:0] i_rd_addr,
   output logic [DBITS-1:0] o_rd_data
);

   logic [DBITS-1:0] mem [2**ABITS]; // storage array.

   // write port.
   always_ff @(posedge clock) begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
   end

   // read port, one cycle of latency.
   always_ff @(posedge clock) begin
      o_rd_data <= mem[i_rd_addr];
   end

endmodule

//--- design/fwft_fifo.sv
// fwft_fifo: single-clock first-word-fall-through FIFO with an early ready for the writer.

`timescale 1ns/1ns

module fwft_fifo #(
   parameter int DBITS = 64,
   parameter int DEPTH_LOG2 = 5
) (
   input  logic clock,
   input  logic i_rst,
   input  logic [DBITS-1:0] i_data,
   input  logic i_wr,
   output logic o_ready,
   input  logic i_rd,
   output logic [DBITS-1:0] o_data,
   output logic o_valid
);

   localparam int DEPTH = 2**DEPTH_LOG2;
   localparam int MIN_FREE = 4; // two words in flight plus margin.

   logic [DBITS-1:0] mem [DEPTH]; // circular buffer.
   logic [DEPTH_LOG2:0] wr_ptr; // extra bit tells full from empty.
   logic [DEPTH_LOG2:0] rd_ptr;
   logic [DEPTH_LOG2:0] count; // words held.
   logic [DEPTH_LOG2:0] free; // slots left.
   logic rd_take; // head word consumed.

   assign count = wr_ptr - rd_ptr;
   assign free = (DEPTH_LOG2+1)'(DEPTH) - count;
   assign rd_take = i_rd && o_valid;

   // head word shown at once.
   assign o_valid = (count != '0);
   assign o_data = mem[rd_ptr[DEPTH_LOG2-1:0]];
   assign o_ready = (free >= (DEPTH_LOG2+1)'(MIN_FREE)); // drops early.

   // payload store.
   always_ff @(posedge clock) begin
      if (i_wr)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
   end

   // pointers.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (i_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_take)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // the writer must have honored o_ready a few cycles earlier.
   a_no_overflow: assert property (
      @(posedge clock) disable iff (i_rst)
      i_wr |-> (count != (DEPTH_LOG2+1)'(DEPTH))
   ) else $error("fwft_fifo: write into a full buffer");

endmodule

//--- design/hififo_from_pc.sv
// hififo_from_pc: host-to-device DMA channels sharing one read request port.

`timescale 1ns/1ns

module hififo_from_pc #(
   parameter int NUM_FIFOS = hififo_pkg::NUM_FIFOS_DEFAULT
) (
   input  logic clock,
   input  logic i_rst,
   input  hififo_pkg::rc_t i_rc,
   output hififo_pkg::rr_t o_rr,
   input  logic i_rr_ready,
   input  logic [NUM_FIFOS-1:0] i_fifo_read,
   output logic [NUM_FIFOS-1:0][63:0] o_fifo_data,
   output logic [NUM_FIFOS-1:0] o_fifo_valid,
   output logic [NUM_FIFOS-1:0][31:0] o_status
);

   logic [NUM_FIFOS-1:0] req; // per channel request level.
   logic [NUM_FIFOS-1:0][hififo_pkg::BLOCK_BITS-1:0] req_block;
   logic [NUM_FIFOS-1:0] grant; // accept strobe per channel.

   // completions go to every channel, each filters by tag.
   for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_chan
      from_pc_fifo #(.FIFO_INDEX(i)) u_chan (
         .clock(clock),
         .i_rst(i_rst),
         .i_rc(i_rc),
         .o_req(req[i]),
         .o_req_block(req_block[i]),
         .i_grant(grant[i]),
         .i_fifo_read(i_fifo_read[i]),
         .o_fifo_data(o_fifo_data[i]),
         .o_fifo_valid(o_fifo_valid[i]),
         .o_status(o_status[i])
      );
   end

   read_request_arbiter #(.NUM_FIFOS(NUM_FIFOS)) u_arb (
      .clock(clock),
      .i_rst(i_rst),
      .i_req(req),
      .i_req_block(req_block),
      .i_rr_ready(i_rr_ready),
      .o_grant(grant),
      .o_rr(o_rr)
   );

endmodule

//--- design/read_request_arbiter.sv
// read_request_arbiter: round-robin choice of one channel's read request for the host port.

`timescale 1ns/1ns

module read_request_arbiter #(
   parameter int NUM_FIFOS = hififo_pkg::NUM_FIFOS_DEFAULT
) (
   input  logic clock,
   input  logic i_rst,
   input  logic [NUM_FIFOS-1:0] i_req,
   input  logic [NUM_FIFOS-1:0][hififo_pkg::BLOCK_BITS-1:0] i_req_block,
   input  logic i_rr_ready,
   output logic [NUM_FIFOS-1:0] o_grant,
   output hififo_pkg::rr_t o_rr
);

   localparam int SEL_BITS = (NUM_FIFOS > 1) ? $clog2(NUM_FIFOS) : 1;

   hififo_pkg::arb_state_e state;
   logic [SEL_BITS-1:0] sel; // shown channel, then last granted.
   logic [SEL_BITS-1:0] pick; // next requester in rotation.
   logic found;

   // search starts one past the last granted channel.
   always_comb begin
      pick = sel;
      found = 1'b0;
      for (int k = 1; k <= NUM_FIFOS; k++) begin
         if (!found && i_req[(int'(sel) + k) % NUM_FIFOS]) begin
            pick = SEL_BITS'((int'(sel) + k) % NUM_FIFOS);
            found = 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (i_rst) begin
         state <= hififo_pkg::ARB_IDLE;
         sel <= SEL_BITS'(NUM_FIFOS - 1); // channel 0 goes first.
      end else begin
         case (state)
            hififo_pkg::ARB_IDLE: begin
               if (found) begin
                  sel <= pick;
                  state <= hififo_pkg::ARB_HOLD;
               end
            end
            hififo_pkg::ARB_HOLD: begin
               if (i_rr_ready)
                  state <= hififo_pkg::ARB_IDLE; // accepted.
            end
            default: state <= hififo_pkg::ARB_IDLE;
         endcase
      end
   end

   always_comb begin
      o_grant = '0;
      if ((state == hififo_pkg::ARB_HOLD) && i_rr_ready)
         o_grant[sel] = 1'b1; // one-cycle accept strobe.
   end

   assign o_rr.valid = (state == hififo_pkg::ARB_HOLD);
   assign o_rr.tag = {4'(sel), 1'b0, i_req_block[sel]};

   // grant goes to one channel at most, and only to one still asking.
   a_grant_onehot: assert property (
      @(posedge clock) disable iff (i_rst)
      $onehot0(o_grant) && ((o_grant & ~i_req) == '0)
   ) else $error("read_request_arbiter: grant not one-hot or not requested");

   // channel keeps its block steady until the host takes it.
   a_rr_stable: assert property (
      @(posedge clock) disable iff (i_rst)
      (o_rr.valid && !i_rr_ready) |=> (o_rr.valid && $stable(o_rr.tag))
   ) else $error("read_request_arbiter: request changed before accept");

endmodule

//--- from_pc_fifo/from_pc_fifo.sv
// from_pc_fifo: one host-to-device channel, requests blocks and releases them in order.

`timescale 1ns/1ns

module from_pc_fifo #(
   parameter int FIFO_INDEX = 0
) (
   input  logic clock,
   input  logic i_rst,
   input  hififo_pkg::rc_t i_rc,
   output logic o_req,
   output logic [hififo_pkg::BLOCK_BITS-1:0] o_req_block,
   input  logic i_grant,
   input  logic i_fifo_read,
   output logic [63:0] o_fifo_data,
   output logic o_fifo_valid,
   output logic [31:0] o_status
);

   localparam int BB = hififo_pkg::BLOCK_BITS;
   localparam int IB = hififo_pkg::INDEX_BITS;
   localparam int HOLD_BITS = $clog2(hififo_pkg::HOLDOFF_CYCLES + 1);
   localparam int BYTE_BITS = IB + 3; // bytes per block as a shift.
   localparam int FIFO_DEPTH_LOG2 = 5;

   logic [BB-1:0] p_request; // next block to ask for.
   logic [BB-1:0] p_write; // next block to complete in order.
   logic [BB+IB-1:0] p_read; // block and quadword being released.
   logic [hififo_pkg::BLOCKS-1:0] filled; // block fully written.
   logic [HOLD_BITS-1:0] holdoff;
   logic [IB-1:0] out_index; // quadword count at the user side.
   logic [31-BYTE_BITS:0] blocks_out; // blocks read by the user.
   logic [BB-1:0] n_outstanding;

   logic wr_en; // completion for this channel.
   logic wr_last; // last quadword of a block.
   logic [BB-1:0] wr_block;
   logic rd_step; // read pointer advances.
   logic fifo_wr_0; // ram read in progress.
   logic fifo_wr_1; // data register loaded.
   logic [63:0] ram_data;
   logic [63:0] ram_data_q; // pipeline register toward the FIFO.
   logic fifo_ready;
   logic user_take;

   assign wr_block = i_rc.tag[BB-1:0];
   assign wr_en = i_rc.valid && (i_rc.tag[7:4] == 4'(FIFO_INDEX));
   assign wr_last = wr_en && (i_rc.index == IB'(hififo_pkg::QWORDS_PER_BLOCK - 1));

   // outstanding counts until the user has read the whole block.
   assign n_outstanding = p_request - blocks_out[BB-1:0];
   assign o_req = (holdoff == '0) && (n_outstanding < BB'(hififo_pkg::MAX_OUTSTANDING));
   assign o_req_block = p_request;

   assign rd_step = (p_read[BB+IB-1:IB] != p_write) && fifo_ready;
   assign user_take = i_fifo_read && o_fifo_valid;
   assign o_status = {blocks_out, BYTE_BITS'(0)}; // bytes released.

   // request pointer and quiet time.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         p_request <= '0;
         holdoff <= '0;
      end else if (i_grant) begin
         p_request <= p_request + 1'b1;
         holdoff <= HOLD_BITS'(hififo_pkg::HOLDOFF_CYCLES);
      end else if (holdoff != '0) begin
         holdoff <= holdoff - 1'b1;
      end
   end

   // fill marks, write pointer follows them in order.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         filled <= '0;
         p_write <= '0;
      end else begin
         if (filled[p_write]) begin
            filled[p_write] <= 1'b0; // block handed to the read side.
            p_write <= p_write + 1'b1;
         end
         if (wr_last)
            filled[wr_block] <= 1'b1;
      end
   end

   // read pointer and the two-stage write strobe.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         p_read <= '0;
         fifo_wr_0 <= 1'b0;
         fifo_wr_1 <= 1'b0;
      end else begin
         if (rd_step)
            p_read <= p_read + 1'b1;
         fifo_wr_0 <= rd_step;
         fifo_wr_1 <= fifo_wr_0;
      end
   end

   always_ff @(posedge clock) begin
      ram_data_q <= ram_data;
   end

   // user side block count.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         out_index <= '0;
         blocks_out <= '0;
      end else if (user_take) begin
         out_index <= out_index + 1'b1;
         if (out_index == IB'(hififo_pkg::QWORDS_PER_BLOCK - 1))
            blocks_out <= blocks_out + 1'b1;
      end
   end

   block_ram #(.DBITS(64), .ABITS(BB + IB)) u_reorder_ram (
      .clock(clock),
      .i_wr_en(wr_en),
      .i_wr_addr({wr_block, i_rc.index}),
      .i_wr_data(i_rc.data),
      .i_rd_addr(p_read),
      .o_rd_data(ram_data)
   );

   fwft_fifo #(.DBITS(64), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_out_fifo (
      .clock(clock),
      .i_rst(i_rst),
      .i_data(ram_data_q),
      .i_wr(fifo_wr_1),
      .o_ready(fifo_ready),
      .i_rd(i_fifo_read),
      .o_data(o_fifo_data),
      .o_valid(o_fifo_valid)
   );

   // request limit holds across grant and user read timing.
   a_outstanding: assert property (
      @(posedge clock) disable iff (i_rst)
      n_outstanding <= BB'(hififo_pkg::MAX_OUTSTANDING)
   ) else $error("from_pc_fifo %0d: too many blocks outstanding", FIFO_INDEX);

   // host only answers blocks granted earlier and not yet completed.
   a_rc_requested: assert property (
      @(posedge clock) disable iff (i_rst)
      wr_en |-> ((wr_block - p_write) < (p_request - p_write))
   ) else $error("from_pc_fifo %0d: completion for unrequested block", FIFO_INDEX);

endmodule

//--- hififo_from_pc.f
common/hififo_pkg.sv
design/block_ram.sv
design/fwft_fifo.sv
from_pc_fifo/from_pc_fifo.sv
design/read_request_arbiter.sv
design/hififo_from_pc.sv
testbench/clock_gen.sv
testbench/tb_hififo_from_pc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the hififo_from_pc testbench with verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_hififo_from_pc \
   -f hififo_from_pc.f > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_hififo_from_pc > sim.log 2>&1 \
   || { cat sim.log; echo "simulation ended abnormally"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log || { echo "result: no pass line in sim.log"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "result: failing"; exit 1; } \
   || { echo "result: passing"; exit 0; }

//--- testbench/clock_gen.sv
// clock_gen: testbench clock and a synchronous reset held for a few cycles.

`timescale 1ns/1ns

module clock_gen #(
   parameter int PERIOD = 10,
   parameter int RESET_CYCLES = 4,
   parameter int DRIVE_DELAY = 1
) (
   output logic clock,
   output logic o_rst
);

   initial begin
      clock = 1'b0;
      forever #(PERIOD / 2) clock = ~clock; // free running.
   end

   initial begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      #DRIVE_DELAY o_rst = 1'b0; // released just after an edge.
   end

endmodule

//--- testbench/hififo_testdata.txt
// 64-bit hex words for $readmemh, two per line.
// words 0-15 channel 0 block seeds, 16-31 channel 1 block seeds, 32-47 reorder picks.
// channel 0 seeds, blocks 0-15 in request order.
0123456789abcdef fedcba9876543210
1111000022223333 a5a5a5a55a5a5a5a
0000000000000000 ffffffffffffff80
deadbeef00000000 00000000cafef00d
13579bdf2468ace0 8000000000000000
0f0f0f0f0f0f0f0f 7fffffffffffffc0
3c3c3c3c3c3c3c3c 0000000100000000
c3c3c3c3c3c3c3c3 5555555555555555
// channel 1 seeds, blocks 0-15 in request order.
aaaaaaaaaaaaaaaa 0000000000001000
9e3779b97f4a7c15 243f6a8885a308d3
13198a2e03707344 a4093822299f31d0
082efa98ec4e6c89 452821e638d01377
be5466cf34e90c6c c0ac29b7c97c50dd
3f84d5b5b5470917 9216d5d98979fb1b
d1310ba698dfb5ac 2ffd72dbd01adfb7
b8e1afed6a267e96 ba7c9045f12c7f99
// reorder picks, taken modulo the pending list length.
3 0 5 1 2 7 0 4
6 1 3 0 2 5 1 2

//--- testbench/tb_hififo_from_pc.sv
// tb_hififo_from_pc: host memory model and checker for the from-pc DMA channels.

`timescale 1ns/1ns

module tb_hififo_from_pc;

   localparam int NUM_FIFOS = 2;
   localparam int QW = hififo_pkg::QWORDS_PER_BLOCK;
   localparam int BLOCKS_PER_FIFO = 16; // seeds per channel in the data file.
   localparam int WORDS_PER_FIFO = BLOCKS_PER_FIFO * QW;
   localparam int TOTAL_BLOCKS = NUM_FIFOS * BLOCKS_PER_FIFO;
   localparam int N_PICKS = 16; // reorder picks after the seeds.
   localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * QW * 8;
   localparam int DRIVE_DELAY = 1;

   logic clock;
   logic rst;
   hififo_pkg::rc_t rc;
   hififo_pkg::rr_t rr;
   logic rr_ready;
   logic [NUM_FIFOS-1:0] fifo_read;
   logic [NUM_FIFOS-1:0][63:0] fifo_data;
   logic [NUM_FIFOS-1:0] fifo_valid;
   logic [NUM_FIFOS-1:0][31:0] status;

   logic [63:0] tdata [TOTAL_BLOCKS + N_PICKS]; // seeds, then picks.
   integer seed = 32'hcc9;
   int accepted [NUM_FIFOS]; // requests taken per channel.
   int words_read [NUM_FIFOS]; // words popped by the user side.
   int pending [$]; // accepted blocks not yet answered, ch*256+n.
   int mismatch_count;
   int other_count;
   int last_acc; // channel of the last accepted request.
   logic turn_pending; // both channels were asking last cycle.
   int turn_ch;

   clock_gen #(.PERIOD(10), .RESET_CYCLES(4), .DRIVE_DELAY(DRIVE_DELAY)) u_clock (
      .clock(clock),
      .o_rst(rst)
   );

   hififo_from_pc #(.NUM_FIFOS(NUM_FIFOS)) uut (
      .clock(clock),
      .i_rst(rst),
      .i_rc(rc),
      .o_rr(rr),
      .i_rr_ready(rr_ready),
      .i_fifo_read(fifo_read),
      .o_fifo_data(fifo_data),
      .o_fifo_valid(fifo_valid),
      .o_status(status)
   );

   // quadword k of block n: seed plus k.
   function automatic logic [63:0] block_word(int ch, int n, int k);
      return tdata[ch * BLOCKS_PER_FIFO + n] + 64'(k);
   endfunction

   function automatic logic all_read();
      logic done;
      done = 1'b1;
      for (int c = 0; c < NUM_FIFOS; c++)
         done &= (words_read[c] >= WORDS_PER_FIFO);
      return done;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      assert (got == want) else begin
         mismatch_count++;
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, want, got);
      end
   endtask

   task automatic print_counts();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
   endtask

   // an accept happens on the next edge when valid and ready meet here.
   task automatic note_request();
      int ch;
      int n;
      if (rr.valid && rr_ready) begin
         ch = int'(rr.tag[7:4]);
         assert (ch < NUM_FIFOS) else begin
            other_count++;
            $display("request tag %h at %0t names no channel", rr.tag, $time);
         end
         if (ch < NUM_FIFOS) begin
            n = accepted[ch];
            check_value("o_rr.tag", 64'(rr.tag[2:0]), 64'(n % hififo_pkg::BLOCKS));
            if (n < BLOCKS_PER_FIFO)
               pending.push_back(ch * 256 + n); // later blocks never answered.
            accepted[ch]++;
            last_acc = ch;
         end
      end
   endtask

   // user side words in order, and the request limit.
   task automatic note_reads();
      int n;
      int k;
      for (int c = 0; c < NUM_FIFOS; c++) begin
         if (fifo_read[c] && fifo_valid[c]) begin
            n = words_read[c] / QW;
            k = words_read[c] % QW;
            assert (n < BLOCKS_PER_FIFO) else begin
               other_count++;
               $display("channel %0d gave a word past its last block at %0t", c, $time);
            end
            if (n < BLOCKS_PER_FIFO)
               check_value($sformatf("o_fifo_data[%0d]", c), fifo_data[c], block_word(c, n, k));
            words_read[c]++;
         end
         assert (accepted[c] - words_read[c] / QW <= hififo_pkg::MAX_OUTSTANDING) else begin
            other_count++;
            $display("channel %0d has too many blocks outstanding at %0t", c, $time);
         end
      end
   endtask

   // outputs sampled mid-cycle, away from the edges.
   always @(negedge clock) begin
      if (!rst) begin
         if (turn_pending) begin
            turn_pending = 1'b0;
            check_value("o_rr.valid", 64'(rr.valid), 64'd1);
            check_value("o_rr.tag", 64'(rr.tag[7:4]), 64'(turn_ch)); // next in rotation.
         end
         note_request();
         note_reads();
         if (!rr.valid && (uut.req == '1)) begin
            turn_pending = 1'b1;
            turn_ch = (last_acc + 1) % NUM_FIFOS;
         end
      end
   end

   // host accept and user read strobes, one random draw per cycle.
   initial begin : stimulus
      logic [31:0] rnd;
      @(negedge rst);
      forever begin
         @(posedge clock);
         #DRIVE_DELAY;
         rnd = $random(seed);
         rr_ready = (rnd[1:0] == 2'b00); // about one in four.
         for (int c = 0; c < NUM_FIFOS; c++)
            fifo_read[c] = (rnd[4 + 3 * c +: 3] < 3'd3) && (words_read[c] < WORDS_PER_FIFO);
      end
   end

   // host completions, block picked from the pending list by the data file.
   initial begin : completion_driver
      int pick;
      int pick_count;
      int entry;
      int ch;
      int n;
      pick_count = 0;
      @(negedge rst);
      forever begin
         @(posedge clock);
         #DRIVE_DELAY;
         if (pending.size() > 0) begin
            pick = int'(tdata[TOTAL_BLOCKS + pick_count % N_PICKS]) % pending.size();
            pick_count++;
            entry = pending[pick];
            pending.delete(pick);
            ch = entry / 256;
            n = entry % 256;
            for (int k = 0; k < QW; k++) begin
               rc.valid = 1'b1;
               rc.tag = {4'(ch), 1'b0, 3'(n)}; // block number modulo 8.
               rc.index = 6'(k);
               rc.data = block_word(ch, n, k);
               @(posedge clock);
               #DRIVE_DELAY;
            end
            rc = '0; // one idle beat between blocks.
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clock);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      print_counts();
      $display("TESTS FAILED");
      $finish;
   end

   initial begin : main
      rc = '0;
      rr_ready = 1'b0;
      fifo_read = '0;
      mismatch_count = 0;
      other_count = 0;
      last_acc = NUM_FIFOS - 1; // arbiter starts with channel 0.
      turn_pending = 1'b0;
      turn_ch = 0;
      for (int c = 0; c < NUM_FIFOS; c++) begin
         accepted[c] = 0;
         words_read[c] = 0;
      end
      $readmemh("testbench/hififo_testdata.txt", tdata);
      @(negedge rst);
      @(negedge clock); // still reset values here.
      check_value("o_rr.valid", 64'(rr.valid), 64'd0);
      for (int c = 0; c < NUM_FIFOS; c++) begin
         check_value($sformatf("o_fifo_valid[%0d]", c), 64'(fifo_valid[c]), 64'd0);
         check_value($sformatf("o_status[%0d]", c), 64'(status[c]), 64'd0);
      end
      while (!all_read())
         @(negedge clock);
      repeat (4) @(negedge clock); // let the block count settle.
      for (int c = 0; c < NUM_FIFOS; c++)
         check_value($sformatf("o_status[%0d]", c), 64'(status[c]),
                     64'(512 * (words_read[c] / QW)));
      print_counts();
      if (mismatch_count + other_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
